// File: files.f
hw/alu_pkg.sv
hw/operand_issue.sv
hw/condition_eval.sv
hw/arith_unit.sv
hw/logic_shift_unit.sv
hw/addr_stack_unit.sv
hw/result_stage.sv
hw/alu_top.sv
verification/tb_alu_top.sv

// File: hw/addr_stack_unit.sv
/* memory address and stack pointer */
`timescale 1ns/1ps
`default_nettype none

module addr_stack_unit
    import alu_pkg::*;
(
    input  wire operands_t operands,
    input  wire word_t     rs_data,
    input  wire word_t     immediate,
    input  wire logic      mem_disp,
    input  wire logic      en_imm,
    output word_t          res_addr,
    output word_t          next_mem_data,
    output word_t          next_sp,
    output logic           mem_data_load,
    output logic           sp_load
);

    word_t ldst_addr;
    word_t sp_dec;

    assign ldst_addr = mem_disp ? rs_data + immediate : operands.op_b;
    assign sp_dec    = rs_data - stack_step;

    always_comb begin
        res_addr      = '0;
        next_mem_data = operands.op_a;
        next_sp       = sp_dec;
        mem_data_load = 1'b0;
        sp_load       = 1'b0;
        case (operands.op)
            op_ld: res_addr = ldst_addr;
            op_st: begin
                res_addr      = ldst_addr;
                mem_data_load = 1'b1;
            end
            op_push: begin
                res_addr      = sp_dec;
                next_mem_data = en_imm ? immediate : operands.op_a;
                mem_data_load = 1'b1;
                sp_load       = 1'b1;
            end
            op_pop: begin
                res_addr = rs_data;
                next_sp  = rs_data + stack_step;
                sp_load  = 1'b1;
            end
            default: res_addr = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/alu_pkg.sv
/* ALU shared types */
`default_nettype none

package alu_pkg;

    typedef logic [15:0] word_t;

    // word with carry out in bit 16
    typedef logic [16:0] wide_t;

    // stack slot in bytes
    localparam word_t stack_step = 16'd2;

    typedef enum logic [7:0] {
        op_add, op_sub, op_adc, op_sbb, op_cmp,
        op_mov, op_and, op_or, op_xor, op_not,
        op_neg, op_shl, op_shr, op_sar, op_rol,
        op_test, op_set, op_jmp, op_call,
        op_ld, op_st, op_push, op_pop
    } opcode_t;

    typedef enum logic [3:0] {
        cond_always, cond_never, cond_eq, cond_ne,
        cond_cs, cond_cc, cond_os, cond_oc,
        cond_p, cond_n, cond_hi, cond_ls,
        cond_ge, cond_l, cond_g, cond_le
    } cond_t;

    typedef struct packed {
        logic overflow;
        logic sign;
        logic carry;
        logic zero;
    } flags_t;

    typedef struct packed {
        opcode_t op;
        logic    en_imm;
        logic    mem_disp;
        word_t   rd_data;
        word_t   rs_data;
        word_t   immediate;
        cond_t   cond;
        flags_t  flags_in;
    } alu_req_t;

    typedef struct packed {
        word_t   op_a;
        word_t   op_b;
        logic    carry_in;
        opcode_t op;
    } operands_t;

    typedef struct packed {
        wide_t value;
        logic  ov;
    } unit_res_t;

endpackage

`default_nettype wire

// File: hw/alu_top.sv
/* ALU execute stage top */
`timescale 1ns/1ps
`default_nettype none

module alu_top
    import alu_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire logic     en,
    input  wire alu_req_t req,
    output word_t         result,
    output flags_t        flags,
    output logic          write,
    output logic          should_branch,
    output logic          lr_wr_en,
    output word_t         mem_data,
    output word_t         sp_out
);

    operands_t operands;
    logic      write_next;
    logic      ov_class;
    logic      cond_true;
    unit_res_t arith_res;
    unit_res_t logic_res;
    word_t     addr_res;
    word_t     next_mem_data;
    word_t     next_sp;
    logic      mem_data_load;
    logic      sp_load;

    operand_issue u_issue (
        .req        (req),
        .operands   (operands),
        .write_next (write_next),
        .ov_class   (ov_class)
    );

    condition_eval u_cond (
        .cond      (req.cond),
        .flags_in  (req.flags_in),
        .cond_true (cond_true)
    );

    arith_unit u_arith (
        .operands (operands),
        .res      (arith_res)
    );

    logic_shift_unit u_logic (
        .operands (operands),
        .res      (logic_res)
    );

    addr_stack_unit u_addr (
        .operands      (operands),
        .rs_data       (req.rs_data),
        .immediate     (req.immediate),
        .mem_disp      (req.mem_disp),
        .en_imm        (req.en_imm),
        .res_addr      (addr_res),
        .next_mem_data (next_mem_data),
        .next_sp       (next_sp),
        .mem_data_load (mem_data_load),
        .sp_load       (sp_load)
    );

    result_stage u_result (
        .clk           (clk),
        .arst_n        (arst_n),
        .en            (en),
        .op            (req.op),
        .arith_res     (arith_res),
        .logic_res     (logic_res),
        .addr_res      (addr_res),
        .write_next    (write_next),
        .ov_class      (ov_class),
        .cond_true     (cond_true),
        .en_imm        (req.en_imm),
        .immediate     (req.immediate),
        .rd_data       (req.rd_data),
        .next_mem_data (next_mem_data),
        .next_sp       (next_sp),
        .mem_data_load (mem_data_load),
        .sp_load       (sp_load),
        .result        (result),
        .flags         (flags),
        .write         (write),
        .should_branch (should_branch),
        .lr_wr_en      (lr_wr_en),
        .mem_data      (mem_data),
        .sp_out        (sp_out)
    );

endmodule

`default_nettype wire

// File: hw/arith_unit.sv
/* add and subtract unit */
`timescale 1ns/1ps
`default_nettype none

module arith_unit
    import alu_pkg::*;
(
    input  wire operands_t operands,
    output unit_res_t      res
);

    word_t a;
    word_t b;
    wide_t sum;
    logic  b_sign;
    logic  track_ov;

    assign a = operands.op_a;
    assign b = operands.op_b;

    always_comb begin
        sum      = '0;
        b_sign   = b[15];
        track_ov = 1'b1;
        case (operands.op)
            op_add: sum = {1'b0, a} + {1'b0, b};
            op_adc: sum = {1'b0, a} + {1'b0, b} + wide_t'(operands.carry_in);
            op_sub, op_cmp: begin
                sum    = {1'b0, a} - {1'b0, b};
                b_sign = ~b[15];
            end
            op_sbb: begin
                sum    = {1'b0, a} - {1'b0, b} - wide_t'(operands.carry_in);
                b_sign = ~b[15];
            end
            op_neg: begin
                // carry stays clear
                sum      = {1'b0, -a};
                track_ov = 1'b0;
            end
            default: track_ov = 1'b0;
        endcase
    end

    assign res.value = sum;
    assign res.ov    = track_ov && (a[15] == b_sign) && (sum[15] != a[15]);

endmodule

`default_nettype wire

// File: hw/condition_eval.sv
/* branch condition check */
`timescale 1ns/1ps
`default_nettype none

module condition_eval
    import alu_pkg::*;
(
    input  wire cond_t  cond,
    input  wire flags_t flags_in,
    output logic        cond_true
);

    logic ge;

    // signed greater or equal
    assign ge = (flags_in.sign == flags_in.overflow);

    always_comb begin
        case (cond)
            cond_always: cond_true = 1'b1;
            cond_never:  cond_true = 1'b0;
            cond_eq:     cond_true = flags_in.zero;
            cond_ne:     cond_true = ~flags_in.zero;
            cond_cs:     cond_true = flags_in.carry;
            cond_cc:     cond_true = ~flags_in.carry;
            cond_os:     cond_true = flags_in.overflow;
            cond_oc:     cond_true = ~flags_in.overflow;
            cond_p:      cond_true = ~flags_in.sign;
            cond_n:      cond_true = flags_in.sign;
            cond_hi:     cond_true = ~flags_in.carry & ~flags_in.zero;
            cond_ls:     cond_true = flags_in.carry | flags_in.zero;
            cond_ge:     cond_true = ge;
            cond_l:      cond_true = ~ge;
            cond_g:      cond_true = ge & ~flags_in.zero;
            cond_le:     cond_true = ~ge | flags_in.zero;
            default:     cond_true = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/logic_shift_unit.sv
/* logic, move and shift unit */
`timescale 1ns/1ps
`default_nettype none

module logic_shift_unit
    import alu_pkg::*;
(
    input  wire operands_t operands,
    output unit_res_t      res
);

    word_t       a;
    word_t       b;
    logic [31:0] rot;
    word_t       sar_val;

    assign a = operands.op_a;
    assign b = operands.op_b;

    // rotate by the low nibble, amount 0 returns a
    assign rot     = {a, a} >> (5'd16 - {1'b0, b[3:0]});
    assign sar_val = word_t'($signed(a) >>> b[3:0]);

    always_comb begin
        case (operands.op)
            op_and, op_test: res.value = {1'b0, a & b};
            op_or:           res.value = {1'b0, a | b};
            op_xor:          res.value = {1'b0, a ^ b};
            op_not:          res.value = {1'b0, ~a};
            op_mov:          res.value = {1'b0, b};
            // full shift amount, bit 16 catches the last bit out
            op_shl:          res.value = {1'b0, a} << b;
            op_shr:          res.value = {1'b0, a} >> b;
            op_sar:          res.value = {1'b0, sar_val};
            op_rol:          res.value = {1'b0, rot[15:0]};
            default:         res.value = '0;
        endcase
    end

    assign res.ov = 1'b0;

endmodule

`default_nettype wire

// File: hw/operand_issue.sv
/* operand select and opcode decode */
`timescale 1ns/1ps
`default_nettype none

module operand_issue
    import alu_pkg::*;
(
    input  wire alu_req_t req,
    output operands_t     operands,
    output logic          write_next,
    output logic          ov_class
);

    always_comb begin
        operands.op_a     = req.rd_data;
        // immediate replaces the second register
        operands.op_b     = req.en_imm ? req.immediate : req.rs_data;
        operands.carry_in = req.flags_in.carry;
        operands.op       = req.op;
    end

    // ops without a register write-back
    always_comb begin
        case (req.op)
            op_cmp, op_test, op_st, op_jmp, op_push, op_call: begin
                write_next = 1'b0;
            end
            default: begin
                write_next = 1'b1;
            end
        endcase
    end

    // signed add/subtract family
    always_comb begin
        case (req.op)
            op_add, op_sub, op_adc, op_sbb, op_cmp: begin
                ov_class = 1'b1;
            end
            default: begin
                ov_class = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/result_stage.sv
/* result select and output registers */
`timescale 1ns/1ps
`default_nettype none

module result_stage
    import alu_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      arst_n,
    input  wire logic      en,
    input  wire opcode_t   op,
    input  wire unit_res_t arith_res,
    input  wire unit_res_t logic_res,
    input  wire word_t     addr_res,
    input  wire logic      write_next,
    input  wire logic      ov_class,
    input  wire logic      cond_true,
    input  wire logic      en_imm,
    input  wire word_t     immediate,
    input  wire word_t     rd_data,
    input  wire word_t     next_mem_data,
    input  wire word_t     next_sp,
    input  wire logic      mem_data_load,
    input  wire logic      sp_load,
    output word_t          result,
    output flags_t         flags,
    output logic           write,
    output logic           should_branch,
    output logic           lr_wr_en,
    output word_t          mem_data,
    output word_t          sp_out
);

    wide_t next_result;
    logic  next_ov;
    logic  is_branch;
    wide_t result_q;
    logic  ov_q;

    always_comb begin
        case (op)
            op_add, op_sub, op_adc, op_sbb, op_cmp, op_neg: begin
                next_result = arith_res.value;
            end
            op_mov, op_and, op_or, op_xor, op_not, op_test,
            op_shl, op_shr, op_sar, op_rol: begin
                next_result = logic_res.value;
            end
            op_set:          next_result = wide_t'(cond_true);
            op_jmp, op_call: next_result = {1'b0, (en_imm ? immediate : rd_data)};
            op_ld, op_st, op_push, op_pop: begin
                next_result = {1'b0, addr_res};
            end
            default:         next_result = '0;
        endcase
    end

    // logic side never overflows
    assign next_ov   = ov_class ? arith_res.ov : logic_res.ov;
    assign is_branch = (op == op_jmp) || (op == op_call);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_q      <= '0;
            ov_q          <= 1'b0;
            write         <= 1'b0;
            should_branch <= 1'b0;
            lr_wr_en      <= 1'b0;
            mem_data      <= '0;
            sp_out        <= '0;
        end else if (en) begin
            result_q      <= next_result;
            ov_q          <= next_ov;
            write         <= write_next;
            should_branch <= is_branch & cond_true;
            lr_wr_en      <= (op == op_call) & cond_true;
            if (mem_data_load) begin
                mem_data <= next_mem_data;
            end
            if (sp_load) begin
                sp_out <= next_sp;
            end
        end
    end

    assign result = result_q[15:0];

    // flags follow the registered result
    always_comb begin
        flags.overflow = ov_q;
        flags.sign     = result_q[15];
        flags.carry    = result_q[16];
        flags.zero     = (result_q[15:0] == '0);
    end

endmodule

`default_nettype wire

// File: verification/tb_alu_top.sv
/* ALU testbench */
`timescale 1ns/1ps
`default_nettype none

module tb_alu_top
    import alu_pkg::*;
();

    typedef struct packed {
        word_t  result;
        flags_t flags;
        logic   write;
        logic   should_branch;
        logic   lr_wr_en;
        word_t  mem_data;
        word_t  sp_out;
    } outs_t;

    // reset + idle + arith + logic + conditions + mem + gap test + tail
    localparam int planned_cycles = 8 + 3 + 6*20 + 10*20 + 16*3*4 + 4*2*10 + 60*4 + 4;
    localparam int max_cycles     = planned_cycles * 3 / 2;

    logic     clk;
    logic     arst_n;
    logic     en;
    alu_req_t req;
    word_t    result;
    flags_t   flags;
    logic     write;
    logic     should_branch;
    logic     lr_wr_en;
    word_t    mem_data;
    word_t    sp_out;

    logic [31:0] seed;
    outs_t       expected;
    string       test_name;
    string       exp_name;
    int          error_count;
    int          check_count;
    int          cycle_count;

    alu_top dut0 (
        .clk           (clk),
        .arst_n        (arst_n),
        .en            (en),
        .req           (req),
        .result        (result),
        .flags         (flags),
        .write         (write),
        .should_branch (should_branch),
        .lr_wr_en      (lr_wr_en),
        .mem_data      (mem_data),
        .sp_out        (sp_out)
    );

    always #20 clk = ~clk;

    function automatic word_t next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed[31:16];
    endfunction

    function automatic logic cond_holds(cond_t c, flags_t f);
        case (c)
            cond_always: return 1'b1;
            cond_never:  return 1'b0;
            cond_eq:     return f.zero;
            cond_ne:     return !f.zero;
            cond_cs:     return f.carry;
            cond_cc:     return !f.carry;
            cond_os:     return f.overflow;
            cond_oc:     return !f.overflow;
            cond_p:      return !f.sign;
            cond_n:      return f.sign;
            cond_hi:     return !f.carry && !f.zero;
            cond_ls:     return f.carry || f.zero;
            cond_ge:     return f.sign == f.overflow;
            cond_l:      return f.sign != f.overflow;
            cond_g:      return (f.sign == f.overflow) && !f.zero;
            default:     return (f.sign != f.overflow) || f.zero;
        endcase
    endfunction

    function automatic outs_t reset_outs();
        outs_t o;
        o = '0;
        o.flags.zero = 1'b1;
        return o;
    endfunction

    function automatic outs_t ref_alu(alu_req_t r, outs_t prev);
        outs_t       o;
        word_t       a;
        word_t       b;
        word_t       x;
        logic [16:0] full;
        logic        ov;
        logic        c;
        a    = r.rd_data;
        b    = r.en_imm ? r.immediate : r.rs_data;
        c    = cond_holds(r.cond, r.flags_in);
        full = '0;
        ov   = 1'b0;
        x    = a;
        o    = prev;
        o.write         = 1'b1;
        o.should_branch = 1'b0;
        o.lr_wr_en      = 1'b0;
        case (r.op)
            op_add: begin
                full = {1'b0, a} + {1'b0, b};
                ov   = (a[15] == b[15]) && (full[15] != a[15]);
            end
            op_adc: begin
                full = {1'b0, a} + {1'b0, b} + {16'd0, r.flags_in.carry};
                ov   = (a[15] == b[15]) && (full[15] != a[15]);
            end
            op_sub, op_cmp: begin
                full    = {1'b0, a} - {1'b0, b};
                ov      = (a[15] != b[15]) && (full[15] != a[15]);
                o.write = (r.op == op_sub);
            end
            op_sbb: begin
                full = {1'b0, a} - {1'b0, b} - {16'd0, r.flags_in.carry};
                ov   = (a[15] != b[15]) && (full[15] != a[15]);
            end
            op_neg: full = {1'b0, 16'd0 - a};
            op_and: full = {1'b0, a & b};
            op_test: begin
                full    = {1'b0, a & b};
                o.write = 1'b0;
            end
            op_or:  full = {1'b0, a | b};
            op_xor: full = {1'b0, a ^ b};
            op_not: full = {1'b0, ~a};
            op_mov: full = {1'b0, b};
            op_shl: full = (b > 16'd16) ? 17'd0 : ({1'b0, a} << b[4:0]);
            op_shr: full = (b > 16'd15) ? 17'd0 : {1'b0, a >> b[3:0]};
            op_sar: begin
                for (int i = 0; i < b[3:0]; i++) x = {x[15], x[15:1]};
                full = {1'b0, x};
            end
            op_rol: begin
                for (int i = 0; i < b[3:0]; i++) x = {x[14:0], x[15]};
                full = {1'b0, x};
            end
            op_set: full = {16'd0, c};
            op_jmp, op_call: begin
                full            = {1'b0, r.en_imm ? r.immediate : r.rd_data};
                o.write         = 1'b0;
                o.should_branch = c;
                o.lr_wr_en      = (r.op == op_call) && c;
            end
            op_ld: full = {1'b0, r.mem_disp ? r.rs_data + r.immediate : b};
            op_st: begin
                full       = {1'b0, r.mem_disp ? r.rs_data + r.immediate : b};
                o.mem_data = a;
                o.write    = 1'b0;
            end
            op_push: begin
                full       = {1'b0, r.rs_data - 16'd2};
                o.sp_out   = r.rs_data - 16'd2;
                o.mem_data = r.en_imm ? r.immediate : r.rd_data;
                o.write    = 1'b0;
            end
            op_pop: begin
                full     = {1'b0, r.rs_data};
                o.sp_out = r.rs_data + 16'd2;
            end
            default: full = '0;
        endcase
        o.result         = full[15:0];
        o.flags.overflow = ov;
        o.flags.sign     = full[15];
        o.flags.carry    = full[16];
        o.flags.zero     = (full[15:0] == 16'd0);
        return o;
    endfunction

    function automatic alu_req_t rand_req(opcode_t op);
        alu_req_t r;
        word_t    bits;
        bits        = next_rand();
        r.op        = op;
        r.en_imm    = bits[0];
        r.mem_disp  = bits[1];
        r.cond      = cond_t'(bits[7:4]);
        r.flags_in  = bits[11:8];
        r.rd_data   = next_rand();
        r.rs_data   = next_rand();
        r.immediate = next_rand();
        return r;
    endfunction

    task automatic send(alu_req_t r, string name);
        @(posedge clk);
        #2;
        req       = r;
        en        = 1'b1;
        test_name = name;
    endtask

    task automatic idle_cycles(int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            en  = 1'b0;
            // noise on the inputs must not reach the outputs
            req = rand_req(op_add);
        end
    endtask

    task automatic check_field(string test, string field, logic [15:0] exp, logic [15:0] act);
        check_count++;
        assert (act === exp) else begin
            $display("[ERROR] %s %s expected %h actual %h", test, field, exp, act);
            error_count++;
        end
    endtask

    // model follows every accepted request
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            expected <= reset_outs();
            exp_name <= "reset";
        end else if (en) begin
            expected <= ref_alu(req, expected);
            exp_name <= test_name;
        end
    end

    always @(negedge clk) begin
        if (arst_n === 1'b1) begin
            check_field(exp_name, "result", expected.result, result);
            check_field(exp_name, "flags", expected.flags, flags);
            check_field(exp_name, "write", expected.write, write);
            check_field(exp_name, "should_branch", expected.should_branch, should_branch);
            check_field(exp_name, "lr_wr_en", expected.lr_wr_en, lr_wr_en);
            check_field(exp_name, "mem_data", expected.mem_data, mem_data);
            check_field(exp_name, "sp_out", expected.sp_out, sp_out);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > max_cycles) begin
            $display("run stopped after %0d cycles without finishing the tests, checks %0d, errors %0d",
                     cycle_count, check_count, error_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic arith_tests();
        opcode_t ops[6];
        ops = '{op_add, op_sub, op_adc, op_sbb, op_cmp, op_neg};
        foreach (ops[i]) begin
            repeat (20) send(rand_req(ops[i]), "arith");
        end
    endtask

    task automatic logic_shift_tests();
        opcode_t  ops[10];
        alu_req_t r;
        word_t    amt;
        word_t    pick;
        ops = '{op_and, op_or, op_xor, op_not, op_mov, op_test, op_shl, op_shr, op_sar, op_rol};
        foreach (ops[i]) begin
            repeat (20) begin
                r    = rand_req(ops[i]);
                pick = next_rand();
                amt  = next_rand();
                // mostly small amounts, sometimes 16 and above
                if (pick % 3 != 0) begin
                    amt = amt & 16'h001f;
                end
                if (ops[i] inside {op_shl, op_shr, op_sar, op_rol}) begin
                    r.rs_data   = amt;
                    r.immediate = amt;
                end
                send(r, "logic_shift");
            end
        end
    endtask

    task automatic condition_tests();
        opcode_t  ops[3];
        alu_req_t r;
        ops = '{op_set, op_jmp, op_call};
        for (int c = 0; c < 16; c++) begin
            foreach (ops[i]) begin
                repeat (4) begin
                    r      = rand_req(ops[i]);
                    r.cond = cond_t'(c);
                    send(r, "condition");
                end
            end
        end
    endtask

    task automatic mem_stack_tests();
        opcode_t  ops[4];
        alu_req_t r;
        ops = '{op_ld, op_st, op_push, op_pop};
        foreach (ops[i]) begin
            for (int d = 0; d < 2; d++) begin
                repeat (10) begin
                    r          = rand_req(ops[i]);
                    r.mem_disp = d[0];
                    send(r, "mem_stack");
                end
            end
        end
    endtask

    task automatic enable_gap_tests();
        logic [7:0] code;
        word_t      gap;
        repeat (60) begin
            code = 8'(next_rand() % 16'd23);
            send(rand_req(opcode_t'(code)), "en_gap");
            gap = next_rand() % 16'd4;
            idle_cycles(gap);
        end
    endtask

    initial begin
        seed        = 32'd86;
        clk         = 1'b0;
        arst_n      = 1'b1;
        en          = 1'b0;
        req         = '0;
        test_name   = "reset";
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        #1 arst_n = 1'b0;
        repeat (8) @(posedge clk);
        #2 arst_n = 1'b1;
        idle_cycles(3);
        arith_tests();
        logic_shift_tests();
        condition_tests();
        mem_stack_tests();
        enable_gap_tests();
        idle_cycles(2);
        @(negedge clk);
        #1;
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
